/* ram_writer.f */
+incdir+.
ram_writer_pkg.sv
sample_packer.sv
word_fifo.sv
burst_writer.sv
ram_writer_top.sv
axi_mem_model.sv
tb_ram_writer.sv

/* Makefile */
# Verilator flow for ram_writer; any variable can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_ram_writer
FILELIST  ?= ram_writer.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
JOBS      ?= 0

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FILELIST) \
		--top-module $(TOP) -Mdir $(OBJ_DIR)

sim: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx 'Result: PASSED' $(LOG) || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb_ram_writer.sv */
`timescale 1ns/1ps

module tb_ram_writer;

  import ram_writer_pkg::*;

  localparam int NUM_ROWS = 5;

  typedef struct packed {
    byte_addr_t  base;
    int unsigned samples;
    int unsigned aw_pct;
    int unsigned w_pct;
    logic        expect_stall;  // Row is heavy enough to fill the FIFO
  } row_t;

  logic         aclk = 1'b0;
  logic         aresetn;
  logic         s_axis_tvalid;
  sample_t      s_axis_tdata;
  logic         s_axis_tready;
  byte_addr_t   cfg_base;
  word_offset_t sts_words;
  aw_chan_t     m_axi_aw;
  logic         m_axi_awvalid;
  logic         m_axi_awready;
  w_chan_t      m_axi_w;
  logic         m_axi_wvalid;
  logic         m_axi_wready;
  int unsigned  aw_pct;
  int unsigned  w_pct;
  row_t         rows [NUM_ROWS];
  int unsigned  cycles = 0;
  int unsigned  limit = 0;
  int           errors = 0;
  int           checks = 0;

  ram_writer_top dut_i (.*);

  axi_mem_model mem_i (
    .aclk    (aclk),
    .aresetn (aresetn),
    .base    (cfg_base),
    .aw_pct  (aw_pct),
    .w_pct   (w_pct),
    .aw      (m_axi_aw),
    .awvalid (m_axi_awvalid),
    .awready (m_axi_awready),
    .w       (m_axi_w),
    .wvalid  (m_axi_wvalid),
    .wready  (m_axi_wready)
  );

  initial
  begin
    forever #4 aclk = !aclk;
  end

  always @(posedge aclk)
  begin
    cycles++;
    if (cycles > limit)
    begin
      $display("timeout: run did not finish within %0d cycles", limit);
      $display("Result: FAILED");
      $finish;
    end
  end

  function automatic sample_t sample_value(int row, int unsigned idx);
    return {8'(row), 24'(idx)};  // Row in the top byte, counter below
  endfunction

  task automatic compare_value(string name, logic [63:0] got, logic [63:0] exp);
    checks++;
    assert (got === exp) else
    begin
      errors++;
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic require(bit cond, string what);
    checks++;
    assert (cond) else
    begin
      errors++;
      $display("error at %0t: %s", $time, what);
    end
  endtask

  task automatic reset_dut(row_t r);
    @(posedge aclk);
    aresetn <= 1'b0;
    s_axis_tvalid <= 1'b0;
    cfg_base <= r.base;
    aw_pct <= r.aw_pct;
    w_pct <= r.w_pct;
    repeat (16) @(posedge aclk);
    aresetn <= 1'b1;
    @(negedge aclk);
    compare_value("m_axi_awvalid", 64'(m_axi_awvalid), 64'(0));
    compare_value("m_axi_wvalid", 64'(m_axi_wvalid), 64'(0));
    compare_value("s_axis_tready", 64'(s_axis_tready), 64'(1));
    compare_value("sts_words", 64'(sts_words), 64'(0));
  endtask

  task automatic send_samples(int row, row_t r, output bit stall_seen);
    int unsigned idx;
    idx = 0;
    stall_seen = 1'b0;
    while (idx < r.samples)
    begin
      @(posedge aclk);
      if (!s_axis_tready)
      begin
        stall_seen = 1'b1;
      end
      if (s_axis_tvalid && s_axis_tready)
      begin
        idx++;
      end
      if (!s_axis_tvalid || s_axis_tready)  // A refused sample stays on the bus
      begin
        s_axis_tvalid <= (idx < r.samples) && (($urandom % 100) < 75);
        s_axis_tdata <= sample_value(row, idx);
      end
    end
  endtask

  task automatic drain_and_verify(int row, row_t r, bit stall_seen);
    int unsigned words;
    byte_addr_t  addr;
    word_t       expected;
    words = (r.samples / 32) * 16;  // Only complete bursts reach memory
    @(negedge aclk);
    while (mem_i.stored_words < words || m_axi_awvalid || m_axi_wvalid)
    begin
      @(negedge aclk);
    end
    repeat (32) @(negedge aclk);  // Room for a stray beat to show up
    compare_value("sts_words", 64'(sts_words), 64'(words));
    compare_value("beat count", 64'(mem_i.beat_count), 64'(words));
    compare_value("burst count", 64'(mem_i.aw_count), 64'(words / 16));
    for (int unsigned k = 0; k < words; k++)
    begin
      addr = r.base + byte_addr_t'(k * 8);
      expected = {sample_value(row, 2 * k + 1), sample_value(row, 2 * k)};
      require(mem_i.mem.exists(addr) != 0,
              $sformatf("row %0d: word %0d never written at %h", row, k, addr));
      if (mem_i.mem.exists(addr) != 0)
      begin
        compare_value($sformatf("mem[%h]", addr), mem_i.mem[addr], expected);
      end
    end
    if (r.expect_stall)
    begin
      require(stall_seen, $sformatf("row %0d: tready never dropped under back-pressure", row));
    end
  endtask

  initial
  begin
    bit stall_seen;
    void'($urandom(3028));
    aresetn = 1'b0;
    s_axis_tvalid = 1'b0;
    s_axis_tdata = '0;
    cfg_base = '0;
    aw_pct = 100;
    w_pct = 100;
    // Base, samples, AW ready %, W ready %, expect tready low
    rows[0] = '{32'h0000_0000, 64, 100, 100, 1'b0};
    rows[1] = '{32'h1000_0000, 100, 70, 60, 1'b0};    // Four samples left over
    rows[2] = '{32'h2000_1000, 31, 100, 100, 1'b0};   // Not even one burst
    rows[3] = '{32'h3000_0800, 4000, 10, 10, 1'b1};
    rows[4] = '{32'h0800_0000, 2100, 50, 30, 1'b0};   // Burst id wraps
    foreach (rows[i])
    begin
      limit += 8 * rows[i].samples;
    end
    limit += 1000;
    for (int i = 0; i < NUM_ROWS; i++)
    begin
      reset_dut(rows[i]);
      send_samples(i, rows[i], stall_seen);
      drain_and_verify(i, rows[i], stall_seen);
    end
    $display("checks: %0d, errors: %0d in testbench, %0d in memory model",
             checks, errors, mem_i.errors);
    if (errors == 0 && mem_i.errors == 0)
    begin
      $display("Result: PASSED");
    end
    else
    begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* axi_mem_model.sv */
`timescale 1ns/1ps

module axi_mem_model
(
  input  logic                       aclk,
  input  logic                       aresetn,
  input  ram_writer_pkg::byte_addr_t base,
  input  int unsigned                aw_pct,          // Chance of awready in percent
  input  int unsigned                w_pct,           // Chance of wready in percent
  input  ram_writer_pkg::aw_chan_t   aw,
  input  logic                       awvalid,
  output logic                       awready = 1'b0,
  input  ram_writer_pkg::w_chan_t    w,
  input  logic                       wvalid,
  output logic                       wready = 1'b0
);

  import ram_writer_pkg::*;

  word_t       mem [byte_addr_t];  // Stored beats by byte address
  byte_addr_t  aw_addr_q [$];
  axi_id_t     aw_id_q [$];
  w_chan_t     beat_q [$];         // Beats still waiting for their address
  int unsigned aw_count;
  int unsigned beat_count;
  int unsigned stored_words;
  int          errors = 0;

  always @(posedge aclk)
  begin : track
    w_chan_t    beat;
    byte_addr_t addr;
    if (!aresetn)
    begin
      awready <= 1'b0;
      wready <= 1'b0;
      mem.delete();
      aw_addr_q.delete();
      aw_id_q.delete();
      beat_q.delete();
      aw_count = 0;
      beat_count = 0;
      stored_words = 0;
    end
    else
    begin
      awready <= ($urandom % 100) < aw_pct;
      wready <= ($urandom % 100) < w_pct;
      if (awvalid && awready)
      begin
        addr = base + byte_addr_t'(aw_count * 128);  // 16 beats of 8 bytes each
        assert (aw.addr == addr && aw.id == axi_id_t'(aw_count)) else
        begin
          errors++;
          $display("mismatch at %0t: m_axi_aw got %h expected %h", $time, aw,
                   {axi_id_t'(aw_count), addr});
        end
        aw_addr_q.push_back(aw.addr);
        aw_id_q.push_back(aw.id);
        aw_count++;
      end
      if (wvalid && wready)
      begin
        assert (w.last == (beat_count % 16 == 15)) else
        begin
          errors++;
          $display("mismatch at %0t: m_axi_w.last got %b expected %b", $time, w.last,
                   beat_count % 16 == 15);
        end
        beat_q.push_back(w);
        beat_count++;
      end
      // W may run ahead of AW, so beats wait here for their burst address
      while (beat_q.size() > 0 && aw_id_q.size() > stored_words / 16)
      begin
        beat = beat_q.pop_front();
        assert (beat.id == aw_id_q[stored_words / 16]) else
        begin
          errors++;
          $display("mismatch at %0t: m_axi_w.id got %h expected %h", $time, beat.id,
                   aw_id_q[stored_words / 16]);
        end
        mem[aw_addr_q[stored_words / 16] + byte_addr_t'((stored_words % 16) * 8)] = beat.data;
        stored_words++;
      end
    end
  end

endmodule

/* ram_writer_top.sv */
`timescale 1ns/1ps
`include "ram_writer_config.svh"

module ram_writer_top
(
  input  logic                             aclk,
  input  logic                             aresetn,

  // Sample stream in
  input  logic                             s_axis_tvalid,
  input  ram_writer_pkg::sample_t          s_axis_tdata,
  output logic                             s_axis_tready,

  // Sideband
  input  ram_writer_pkg::byte_addr_t       cfg_base,
  output ram_writer_pkg::word_offset_t     sts_words,

  // AXI3 write master, address and data channels
  output ram_writer_pkg::aw_chan_t         m_axi_aw,
  output logic                             m_axi_awvalid,
  input  logic                             m_axi_awready,
  output ram_writer_pkg::w_chan_t          m_axi_w,
  output logic                             m_axi_wvalid,
  input  logic                             m_axi_wready
);

  import ram_writer_pkg::*;

  logic                            push;
  word_t                           push_word;
  logic                            full;
  word_t                           head;
  logic                            pop;
  logic [$clog2(`RW_FIFO_DEPTH):0] level;

  sample_packer packer_i (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tready (s_axis_tready),
    .full          (full),
    .push          (push),
    .push_word     (push_word)
  );

  word_fifo #(
    .DEPTH (`RW_FIFO_DEPTH)
  ) fifo_i (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .push      (push),
    .push_word (push_word),
    .pop       (pop),
    .head      (head),
    .full      (full),
    .level     (level)
  );

  burst_writer writer_i (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .cfg_base  (cfg_base),
    .level     (level),
    .head      (head),
    .pop       (pop),
    .aw        (m_axi_aw),
    .awvalid   (m_axi_awvalid),
    .awready   (m_axi_awready),
    .w         (m_axi_w),
    .wvalid    (m_axi_wvalid),
    .wready    (m_axi_wready),
    .sts_words (sts_words)
  );

endmodule

/* burst_writer.sv */
`timescale 1ns/1ps
`include "ram_writer_config.svh"

module burst_writer
(
  input  logic                             aclk,
  input  logic                             aresetn,
  input  ram_writer_pkg::byte_addr_t       cfg_base,
  input  logic [$clog2(`RW_FIFO_DEPTH):0]  level,
  input  ram_writer_pkg::word_t            head,
  output logic                             pop,
  output ram_writer_pkg::aw_chan_t         aw,
  output logic                             awvalid,
  input  logic                             awready,
  output ram_writer_pkg::w_chan_t          w,
  output logic                             wvalid,
  input  logic                             wready,
  output ram_writer_pkg::word_offset_t     sts_words
);

  import ram_writer_pkg::*;

  localparam int LW = $clog2(`RW_FIFO_DEPTH) + 1;
  localparam int BYTE_SHIFT = $clog2(`RW_WORD_WIDTH / 8);
  localparam int BEAT_BITS = $clog2(`RW_BURST_LEN);

  burst_state_e  state_q;
  burst_state_e  state_d;
  word_offset_t  offset_q;     // Word count, also the beat position in the burst
  word_offset_t  offset_d;
  axi_id_t       id_q;         // Id of the burst on the W channel
  axi_id_t       id_d;
  aw_chan_t      aw_q;         // Address on the bus
  aw_chan_t      pend_q;       // Address owed for a burst whose beats already run
  aw_chan_t      start_aw;
  logic          awvalid_q;
  logic          pend_valid_q;
  logic          aw_fire;
  logic          aw_free;
  logic          last_beat;
  logic          start;
  logic [LW-1:0] level_left;

  assign aw_fire = awvalid_q && awready;
  assign aw_free = !awvalid_q || aw_fire;
  assign wvalid = (state_q == st_burst);
  assign pop = wvalid && wready;
  assign last_beat = pop && (&offset_q[BEAT_BITS-1:0]);
  assign level_left = level - LW'(pop);

  assign offset_d = offset_q + word_offset_t'(pop);
  assign id_d = id_q + axi_id_t'(last_beat);

  // Address of the burst that starts now, taken from the updated offset
  always_comb
  begin
    start_aw.id = id_d;
    start_aw.addr = cfg_base + (byte_addr_t'(offset_d) << BYTE_SHIFT);
  end

  always_comb
  begin
    state_d = state_q;
    start = 1'b0;
    case (state_q)
      st_idle:
        if (level_left >= LW'(`RW_BURST_LEN) && !pend_valid_q)
        begin
          start = 1'b1;
          state_d = st_burst;
        end
      st_burst:
        if (last_beat)
        begin
          if (level_left >= LW'(`RW_BURST_LEN) && !pend_valid_q)
          begin
            start = 1'b1;  // Back to back, wvalid stays up
          end
          else
          begin
            state_d = st_idle;
          end
        end
      default: state_d = st_idle;
    endcase
  end

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      state_q <= st_idle;
      offset_q <= '0;
      id_q <= '0;
      awvalid_q <= 1'b0;
      pend_valid_q <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      offset_q <= offset_d;
      id_q <= id_d;
      if (pend_valid_q && aw_fire)
      begin
        pend_valid_q <= 1'b0;  // Owed address follows, awvalid stays high
      end
      else if (start && aw_free)
      begin
        awvalid_q <= 1'b1;
      end
      else if (start)
      begin
        pend_valid_q <= 1'b1;
      end
      else if (aw_fire)
      begin
        awvalid_q <= 1'b0;
      end
    end
  end

  // Address payloads, loaded only when the bus can take them
  always_ff @(posedge aclk)
  begin
    if (pend_valid_q && aw_fire)
    begin
      aw_q <= pend_q;
    end
    else if (start && aw_free)
    begin
      aw_q <= start_aw;
    end
    if (start && !aw_free)
    begin
      pend_q <= start_aw;
    end
  end

  assign aw = aw_q;
  assign awvalid = awvalid_q;
  assign sts_words = offset_q;

  always_comb
  begin
    w.id = id_q;
    w.data = head;
    w.last = &offset_q[BEAT_BITS-1:0];  // 16th beat of the burst
  end

  a_aw_stable: assert property (
    @(posedge aclk) disable iff (!aresetn) awvalid && !awready |=> $stable(aw)
  ) else $error("burst_writer: AW payload changed while stalled");

  a_w_has_data: assert property (
    @(posedge aclk) disable iff (!aresetn) wvalid |-> (level != '0)
  ) else $error("burst_writer: wvalid with an empty FIFO");

endmodule

/* word_fifo.sv */
`timescale 1ns/1ps
`include "ram_writer_config.svh"

module word_fifo
#(
  parameter int DEPTH = `RW_FIFO_DEPTH
)
(
  input  logic                   aclk,
  input  logic                   aresetn,
  input  logic                   push,
  input  ram_writer_pkg::word_t  push_word,
  input  logic                   pop,
  output ram_writer_pkg::word_t  head,
  output logic                   full,
  output logic [$clog2(DEPTH):0] level
);

  import ram_writer_pkg::*;

  localparam int PW = $clog2(DEPTH);

  // Pointers wrap on their own, so the depth has to be a power of two
  if ((2 ** PW) != DEPTH)
  begin : g_depth_check
    $error("word_fifo: DEPTH must be a power of two");
  end

  word_t         mem [DEPTH];
  logic [PW-1:0] wr_ptr_q;
  logic [PW-1:0] rd_ptr_q;
  logic [PW:0]   count_q;
  logic          empty;

  assign empty = (count_q == '0);
  assign full = (count_q == (PW + 1)'(DEPTH));
  assign level = count_q;
  assign head = mem[rd_ptr_q];  // Fall-through read

  always_ff @(posedge aclk)
  begin
    if (push)
    begin
      mem[wr_ptr_q] <= push_word;
    end
  end

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q <= '0;
    end
    else
    begin
      if (push)
      begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop)
      begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10: count_q <= count_q + 1'b1;
        2'b01: count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // Both or neither
      endcase
    end
  end

  a_no_pop_when_empty: assert property (
    @(posedge aclk) disable iff (!aresetn) pop |-> !empty
  ) else $error("word_fifo: pop while empty");

  a_no_push_when_full: assert property (
    @(posedge aclk) disable iff (!aresetn) push |-> !full
  ) else $error("word_fifo: push while full");

endmodule

/* sample_packer.sv */
`timescale 1ns/1ps

module sample_packer
(
  input  logic                    aclk,
  input  logic                    aresetn,
  input  logic                    s_axis_tvalid,
  input  ram_writer_pkg::sample_t s_axis_tdata,
  output logic                    s_axis_tready,
  input  logic                    full,
  output logic                    push,
  output ram_writer_pkg::word_t   push_word
);

  import ram_writer_pkg::*;

  sample_t first_q;  // Earlier sample of the pair
  logic    phase_q;  // High while first_q waits for its partner
  logic    accept;

  assign s_axis_tready = !full;
  assign accept = s_axis_tvalid && s_axis_tready;

  // The second sample goes straight into the FIFO along with the held one
  assign push = accept && phase_q;
  assign push_word = {s_axis_tdata, first_q};

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      phase_q <= 1'b0;
    end
    else if (accept)
    begin
      phase_q <= !phase_q;  // Refused samples leave the phase alone
    end
  end

  always_ff @(posedge aclk)
  begin
    if (accept && !phase_q)
    begin
      first_q <= s_axis_tdata;
    end
  end

  // Pairing relies on a refused sample staying on the stream until it is taken
  a_hold_refused: assert property (
    @(posedge aclk) disable iff (!aresetn)
    s_axis_tvalid && !s_axis_tready |=> s_axis_tvalid && $stable(s_axis_tdata)
  ) else $error("sample_packer: refused sample changed before it was accepted");

endmodule

/* ram_writer_pkg.sv */
`include "ram_writer_config.svh"

package ram_writer_pkg;

  // Widths with a meaning of their own
  typedef logic [`RW_SAMPLE_WIDTH-1:0] sample_t;
  typedef logic [`RW_WORD_WIDTH-1:0] word_t;        // Later sample in the upper half
  typedef logic [`RW_AXI_ADDR_WIDTH-1:0] byte_addr_t;
  typedef logic [`RW_OFFSET_WIDTH-1:0] word_offset_t; // Words written since reset
  typedef logic [`RW_ID_WIDTH-1:0] axi_id_t;

  // Write address channel payload
  typedef struct packed {
    axi_id_t    id;
    byte_addr_t addr;
  } aw_chan_t;

  // Write data channel payload, one beat
  typedef struct packed {
    axi_id_t id;
    word_t   data;
    logic    last;
  } w_chan_t;

  // Burst writer FSM
  typedef enum logic [0:0] {
    st_idle,  // Waiting for a full burst in the FIFO
    st_burst  // Streaming beats
  } burst_state_e;

endpackage

/* ram_writer_config.svh */
`ifndef RAM_WRITER_CONFIG_SVH
`define RAM_WRITER_CONFIG_SVH

// Stream side
`define RW_SAMPLE_WIDTH 32     // One AXI-Stream sample

// Memory side
`define RW_WORD_WIDTH 64       // One AXI write beat, two samples
`define RW_AXI_ADDR_WIDTH 32   // Byte address
`define RW_ID_WIDTH 6          // AWID and WID

// Word offset counter, wraps at this width
`define RW_OFFSET_WIDTH 20

// Every burst is this many full-width INCR beats
`define RW_BURST_LEN 16

// Buffer between packer and burst writer, in words
`define RW_FIFO_DEPTH 512

`endif
